//--- Bender.yml
package:
  name: ao_peripheral_subsystem

sources:
  - verilog/ao_periph_pkg.sv
  - verilog/reg_bus_if.sv
  - verilog/ao_bus_adapter.sv
  - verilog/ao_reg_demux.sv
  - verilog/soc_ctrl.sv
  - verilog/fast_intr_ctrl.sv
  - verilog/gpio_ao.sv
  - verilog/ao_peripheral_subsystem.sv
  - target: simulation
    files:
      - verif/ao_bus_sva.sv
      - verif/tb_ao_peripheral_subsystem.sv

//--- src.f
verilog/ao_periph_pkg.sv
verilog/reg_bus_if.sv
verilog/ao_bus_adapter.sv
verilog/ao_reg_demux.sv
verilog/soc_ctrl.sv
verilog/fast_intr_ctrl.sv
verilog/gpio_ao.sv
verilog/ao_peripheral_subsystem.sv
verif/ao_bus_sva.sv
verif/tb_ao_peripheral_subsystem.sv

//--- verif/ao_bus_sva.sv
// Request handshake checks for the subsystem top level
// Grant only with a request, response exactly one cycle after each grant

`timescale 1ns/1ps

module ao_bus_sva (
  input logic clk_i,
  input logic reset_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i
);

  int unsigned fail_count = 0;

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    gnt_i |=> rvalid_i)
    else begin
      fail_count++;
      $error("bus_rvalid_o missing in the cycle after a grant");
    end

  a_rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i |-> $past(gnt_i))
    else begin
      fail_count++;
      $error("bus_rvalid_o high without a grant in the previous cycle");
    end

  // Single outstanding response
  a_no_gnt_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i |-> !gnt_i)
    else begin
      fail_count++;
      $error("bus_gnt_o high while a response is outstanding");
    end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    gnt_i |-> req_i)
    else begin
      fail_count++;
      $error("bus_gnt_o high without bus_req_i");
    end

endmodule : ao_bus_sva

bind ao_peripheral_subsystem ao_bus_sva u_bus_sva (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .req_i    (bus_req_i),
  .gnt_i    (bus_gnt_o),
  .rvalid_i (bus_rvalid_o)
);

//--- verif/ao_test_input.txt
# W addr data exp_err | R addr exp_rdata exp_err (all hex)
# P boot fast_in gpio_in exp_exit_valid exp_exit_value exp_fast_out exp_gpio_out exp_gpio_en exp_intr_gpio
R 000 00000000 0
W 004 CAFE0001 0
P 0 0000 00 0 CAFE0001 0000 00 00 00
W 000 00000001 0
R 004 CAFE0001 0
P 1 0000 00 1 CAFE0001 0000 00 00 00
R 008 00000001 0
R 00C 000A0001 0
W 200 000000A5 0
W 204 000000F0 0
R 200 000000A5 0
P 1 0000 3C 1 CAFE0001 0000 A5 F0 00
R 208 0000003C 0
W 20C 0000000F 0
P 1 0000 3C 1 CAFE0001 0000 A5 F0 0C
P 1 0012 3C 1 CAFE0001 0000 A5 F0 0C
P 1 0000 3C 1 CAFE0001 0000 A5 F0 0C
R 100 00000012 0
W 108 00000002 0
P 1 0000 3C 1 CAFE0001 0002 A5 F0 0C
W 104 00000012 0
R 100 00000000 0
P 1 0000 3C 1 CAFE0001 0000 A5 F0 0C
R 108 00000002 0
W 300 FFFFFFFF 1
R 304 00000000 1
R 000 00000001 0
R 004 CAFE0001 0
R 200 000000A5 0
R 104 00000000 0

//--- verif/tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Replays bus and pin operations from a test file and checks every response

`timescale 1ns/1ps

module tb_ao_peripheral_subsystem;

  localparam string TEST_FILE = "verif/ao_test_input.txt";

  logic                                    clk_i;
  logic                                    reset_i;
  logic                                    bus_req_i;
  logic                                    bus_we_i;
  logic [ao_periph_pkg::AW-1:0]            bus_addr_i;
  logic [ao_periph_pkg::DW-1:0]            bus_wdata_i;
  logic                                    bus_gnt_o;
  logic                                    bus_rvalid_o;
  logic [ao_periph_pkg::DW-1:0]            bus_rdata_o;
  logic                                    bus_err_o;
  logic                                    boot_select_i;
  logic                                    exit_valid_o;
  logic [ao_periph_pkg::DW-1:0]            exit_value_o;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o;
  logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_i;
  logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_o;
  logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_en_o;
  logic [ao_periph_pkg::NUM_GPIO-1:0]      intr_gpio_o;

  int unsigned check_count    = 0;
  int unsigned mismatch_count = 0;
  int unsigned other_count    = 0;
  int unsigned cycle_count    = 0;
  int unsigned cycle_limit    = 50;

  ao_peripheral_subsystem u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_word(input string name, input logic [ao_periph_pkg::DW-1:0] actual,
                            input logic [ao_periph_pkg::DW-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // One request on the memory-style port, response checked one cycle after the grant
  // Starts on a falling edge
  // A following request overlaps the response cycle and must wait for its grant
  task automatic bus_access(input logic we, input logic [ao_periph_pkg::AW-1:0] addr,
                            input logic [ao_periph_pkg::DW-1:0] wdata,
                            input logic [ao_periph_pkg::DW-1:0] exp_rdata,
                            input logic exp_err);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    // Grant is sampled at the edge that ends the grant cycle
    do begin
      @(posedge clk_i);
    end while (bus_gnt_o !== 1'b1);
    @(negedge clk_i);
    bus_req_i = 1'b0;
    check_bit("bus_rvalid_o", bus_rvalid_o, 1'b1);
    check_word("bus_rdata_o", bus_rdata_o, exp_rdata);
    check_bit("bus_err_o", bus_err_o, exp_err);
  endtask

  task automatic apply_pins(input logic boot,
                            input logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fi,
                            input logic [ao_periph_pkg::NUM_GPIO-1:0] gpio);
    @(negedge clk_i);
    boot_select_i = boot;
    fast_intr_i   = fi;
    cio_gpio_i    = gpio;
    // Room for the 2-flop GPIO synchronizer
    repeat (3) @(negedge clk_i);
  endtask

  initial begin : watchdog
    @(posedge clk_i);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int          fd;
    int          n;
    int unsigned line_count;
    bit          abort;
    byte         op;
    string       text;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_err;
    logic [31:0] pf [9];

    line_count    = 0;
    abort         = 1'b0;
    reset_i       = 1'b1;
    bus_req_i     = 1'b0;
    bus_we_i      = 1'b0;
    bus_addr_i    = '0;
    bus_wdata_i   = '0;
    boot_select_i = 1'b0;
    fast_intr_i   = '0;
    cio_gpio_i    = '0;

    // Run length bound from the size of the test file
    fd = $fopen(TEST_FILE, "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        line_count++;
      end
      $fclose(fd);
    end
    cycle_limit = 10 * line_count + 50;

    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    check_bit("bus_rvalid_o", bus_rvalid_o, 1'b0);
    check_bit("exit_valid_o", exit_valid_o, 1'b0);
    check_word("cio_gpio_en_o", cio_gpio_en_o, '0);

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      other_count++;
      $display("Error: test file %s could not be opened", TEST_FILE);
    end else begin
      while (!abort && $fscanf(fd, " %c", op) == 1) begin
        case (op)
          "#": void'($fgets(text, fd));
          "W", "R": begin
            n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_err);
            if (n != 3) begin
              other_count++;
              abort = 1'b1;
              $display("Error: bus operation in the test file has missing fields");
            end else if (op == "W") begin
              bus_access(1'b1, f_addr, f_data, '0, f_err[0]);
            end else begin
              bus_access(1'b0, f_addr, '0, f_data, f_err[0]);
            end
          end
          "P": begin
            // Pins in, then expected exit, fast interrupt and GPIO outputs
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", pf[0], pf[1], pf[2],
                        pf[3], pf[4], pf[5], pf[6], pf[7], pf[8]);
            if (n != 9) begin
              other_count++;
              abort = 1'b1;
              $display("Error: pin operation in the test file has missing fields");
            end else begin
              apply_pins(pf[0][0],
                         pf[1][ao_periph_pkg::NUM_FAST_INTR-1:0],
                         pf[2][ao_periph_pkg::NUM_GPIO-1:0]);
              check_bit("exit_valid_o", exit_valid_o, pf[3][0]);
              check_word("exit_value_o", exit_value_o, pf[4]);
              check_word("fast_intr_o", fast_intr_o, pf[5]);
              check_word("cio_gpio_o", cio_gpio_o, pf[6]);
              check_word("cio_gpio_en_o", cio_gpio_en_o, pf[7]);
              check_word("intr_gpio_o", intr_gpio_o, pf[8]);
            end
          end
          default: begin
            other_count++;
            abort = 1'b1;
            $display("Error: unknown operation '%c' in the test file", op);
          end
        endcase
      end
      $fclose(fd);
    end

    @(negedge clk_i);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
             check_count, mismatch_count, other_count, u_dut.u_bus_sva.fail_count);
    if (mismatch_count == 0 && other_count == 0 && u_dut.u_bus_sva.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

//--- verilog/ao_bus_adapter.sv
// Request/grant/rvalid port to register bus adapter
// One transaction in flight, response one cycle after the grant

`timescale 1ns/1ps

module ao_bus_adapter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [ao_periph_pkg::AW-1:0] addr_i,
  input  logic [ao_periph_pkg::DW-1:0] wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [ao_periph_pkg::DW-1:0] rdata_o,
  output logic                         err_o,
  reg_bus_if.host                      bus
);

  logic busy_q;
  logic gnt;

  // Hold off the bus while the previous response is being returned
  assign bus.valid = req_i & ~busy_q;
  assign bus.write = we_i;
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_i;

  assign gnt   = bus.valid & bus.ready;
  assign gnt_o = gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= gnt;
    end
  end

  // Response payload, captured at completion
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_o <= (bus.write || bus.error) ? '0 : bus.rdata;
      err_o   <= bus.error;
    end
  end

  // Busy lasts exactly the response cycle
  assign rvalid_o = busy_q;

endmodule : ao_bus_adapter

//--- verilog/ao_periph_pkg.sv
// Always-on peripheral subsystem shared definitions
// Bus widths, address map and register word offsets

package ao_periph_pkg;

  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;

  // Peripheral select field, address bits 9:8
  localparam int unsigned PERIPH_SEL_MSB = 9;
  localparam int unsigned PERIPH_SEL_LSB = 8;
  localparam int unsigned NUM_PERIPH = 3;

  localparam logic [1:0] SOC_CTRL_IDX  = 2'd0;
  localparam logic [1:0] FAST_INTR_IDX = 2'd1;
  localparam logic [1:0] GPIO_IDX      = 2'd2;

  // Register word offset field, address bits 3:2
  localparam int unsigned REG_OFS_MSB = 3;
  localparam int unsigned REG_OFS_LSB = 2;

  localparam logic [1:0] SOC_EXIT_VALID_OFS = 2'd0;
  localparam logic [1:0] SOC_EXIT_VALUE_OFS = 2'd1;
  localparam logic [1:0] SOC_BOOT_SEL_OFS   = 2'd2;
  localparam logic [1:0] SOC_ID_OFS         = 2'd3;

  localparam logic [1:0] FI_PENDING_OFS = 2'd0;
  localparam logic [1:0] FI_CLEAR_OFS   = 2'd1;
  localparam logic [1:0] FI_ENABLE_OFS  = 2'd2;

  localparam logic [1:0] GPIO_OUT_OFS     = 2'd0;
  localparam logic [1:0] GPIO_EN_OFS      = 2'd1;
  localparam logic [1:0] GPIO_IN_OFS      = 2'd2;
  localparam logic [1:0] GPIO_INTR_EN_OFS = 2'd3;

  localparam logic [31:0] AO_INSTANCE_ID = 32'h000A_0001;

  localparam int unsigned NUM_FAST_INTR    = 16;
  localparam int unsigned NUM_GPIO         = 8;
  localparam int unsigned GPIO_SYNC_STAGES = 2;

endpackage : ao_periph_pkg

//--- verilog/ao_peripheral_subsystem.sv
// Always-on peripheral subsystem top level
// Bus adapter, address demux, SoC control, fast interrupt controller and GPIO

`timescale 1ns/1ps

module ao_peripheral_subsystem (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  // Memory-style request port
  input  logic                                    bus_req_i,
  input  logic                                    bus_we_i,
  input  logic [ao_periph_pkg::AW-1:0]            bus_addr_i,
  input  logic [ao_periph_pkg::DW-1:0]            bus_wdata_i,
  output logic                                    bus_gnt_o,
  output logic                                    bus_rvalid_o,
  output logic [ao_periph_pkg::DW-1:0]            bus_rdata_o,
  output logic                                    bus_err_o,

  // SoC control
  input  logic                                    boot_select_i,
  output logic                                    exit_valid_o,
  output logic [ao_periph_pkg::DW-1:0]            exit_value_o,

  // Fast interrupts
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o,

  // GPIO pins
  input  logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      intr_gpio_o
);

  reg_bus_if up_bus ();
  reg_bus_if soc_bus ();
  reg_bus_if fi_bus ();
  reg_bus_if gpio_bus ();

  ao_bus_adapter u_adapter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (bus_req_i),
    .we_i     (bus_we_i),
    .addr_i   (bus_addr_i),
    .wdata_i  (bus_wdata_i),
    .gnt_o    (bus_gnt_o),
    .rvalid_o (bus_rvalid_o),
    .rdata_o  (bus_rdata_o),
    .err_o    (bus_err_o),
    .bus      (up_bus)
  );

  // Address map decode
  ao_reg_demux u_demux (
    .in_bus   (up_bus),
    .out_soc  (soc_bus),
    .out_fi   (fi_bus),
    .out_gpio (gpio_bus)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (soc_bus),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl u_fast_intr_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus         (fi_bus),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio_ao u_gpio_ao (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (gpio_bus),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

endmodule : ao_peripheral_subsystem

//--- verilog/ao_reg_demux.sv
// Register bus address demux
// Routes each transfer to one peripheral, unmapped space answers with an error

`timescale 1ns/1ps

module ao_reg_demux (
  reg_bus_if.device in_bus,
  reg_bus_if.host   out_soc,
  reg_bus_if.host   out_fi,
  reg_bus_if.host   out_gpio
);

  logic [1:0] sel;
  logic       mapped;

  assign sel    = in_bus.addr[ao_periph_pkg::PERIPH_SEL_MSB:ao_periph_pkg::PERIPH_SEL_LSB];
  assign mapped = (sel < ao_periph_pkg::NUM_PERIPH);

  // Only the selected peripheral sees valid
  assign out_soc.valid  = in_bus.valid & (sel == ao_periph_pkg::SOC_CTRL_IDX);
  assign out_fi.valid   = in_bus.valid & (sel == ao_periph_pkg::FAST_INTR_IDX);
  assign out_gpio.valid = in_bus.valid & (sel == ao_periph_pkg::GPIO_IDX);

  assign out_soc.write  = in_bus.write;
  assign out_soc.addr   = in_bus.addr;
  assign out_soc.wdata  = in_bus.wdata;
  assign out_fi.write   = in_bus.write;
  assign out_fi.addr    = in_bus.addr;
  assign out_fi.wdata   = in_bus.wdata;
  assign out_gpio.write = in_bus.write;
  assign out_gpio.addr  = in_bus.addr;
  assign out_gpio.wdata = in_bus.wdata;

  // Response select, unmapped index answers by itself
  always_comb begin
    in_bus.rdata = '0;
    in_bus.ready = 1'b1;
    in_bus.error = ~mapped;
    case (sel)
      ao_periph_pkg::SOC_CTRL_IDX: begin
        in_bus.rdata = out_soc.rdata;
        in_bus.ready = out_soc.ready;
        in_bus.error = out_soc.error;
      end
      ao_periph_pkg::FAST_INTR_IDX: begin
        in_bus.rdata = out_fi.rdata;
        in_bus.ready = out_fi.ready;
        in_bus.error = out_fi.error;
      end
      ao_periph_pkg::GPIO_IDX: begin
        in_bus.rdata = out_gpio.rdata;
        in_bus.ready = out_gpio.ready;
        in_bus.error = out_gpio.error;
      end
      default: ;
    endcase
  end

endmodule : ao_reg_demux

//--- verilog/fast_intr_ctrl.sv
// Fast interrupt controller
// Sticky pending bits with write-one-to-clear and an enable mask

`timescale 1ns/1ps

module fast_intr_ctrl (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  reg_bus_if.device                               bus,
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o
);

  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] pending_q;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] enable_q;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] clear_mask;
  logic [1:0]                              ofs;
  logic                                    wr;

  assign ofs = bus.addr[ao_periph_pkg::REG_OFS_MSB:ao_periph_pkg::REG_OFS_LSB];
  assign wr  = bus.valid & bus.write;

  assign bus.ready = 1'b1;
  assign bus.error = 1'b0;

  assign clear_mask = (wr && ofs == ao_periph_pkg::FI_CLEAR_OFS) ?
                      bus.wdata[ao_periph_pkg::NUM_FAST_INTR-1:0] : '0;

  // A new event in the clear cycle wins over the clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
      if (wr && ofs == ao_periph_pkg::FI_ENABLE_OFS) begin
        enable_q <= bus.wdata[ao_periph_pkg::NUM_FAST_INTR-1:0];
      end
    end
  end

  // CLEAR and the spare offset read as zero
  always_comb begin
    bus.rdata = '0;
    if (ofs == ao_periph_pkg::FI_PENDING_OFS) begin
      bus.rdata[ao_periph_pkg::NUM_FAST_INTR-1:0] = pending_q;
    end else if (ofs == ao_periph_pkg::FI_ENABLE_OFS) begin
      bus.rdata[ao_periph_pkg::NUM_FAST_INTR-1:0] = enable_q;
    end
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

//--- verilog/gpio_ao.sv
// Always-on GPIO block
// Output and enable registers, synchronized inputs, level interrupts per pin

`timescale 1ns/1ps

module gpio_ao (
  input  logic                               clk_i,
  input  logic                               reset_i,
  reg_bus_if.device                          bus,
  input  logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] intr_gpio_o
);

  logic [ao_periph_pkg::NUM_GPIO-1:0] sync_q [ao_periph_pkg::GPIO_SYNC_STAGES];
  logic [ao_periph_pkg::NUM_GPIO-1:0] gpio_in;
  logic [ao_periph_pkg::NUM_GPIO-1:0] intr_en_q;
  logic [1:0]                         ofs;
  logic                               wr;

  assign ofs = bus.addr[ao_periph_pkg::REG_OFS_MSB:ao_periph_pkg::REG_OFS_LSB];
  assign wr  = bus.valid & bus.write;

  assign bus.ready = 1'b1;
  assign bus.error = 1'b0;

  // Input synchronizer chain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= '{default: '0};
    end else begin
      sync_q[0] <= cio_gpio_i;
      for (int i = 1; i < ao_periph_pkg::GPIO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gpio_in = sync_q[ao_periph_pkg::GPIO_SYNC_STAGES-1];

  // IN is read-only, writes to it fall through
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cio_gpio_o    <= '0;
      cio_gpio_en_o <= '0;
      intr_en_q     <= '0;
    end else if (wr) begin
      case (ofs)
        ao_periph_pkg::GPIO_OUT_OFS:     cio_gpio_o    <= bus.wdata[ao_periph_pkg::NUM_GPIO-1:0];
        ao_periph_pkg::GPIO_EN_OFS:      cio_gpio_en_o <= bus.wdata[ao_periph_pkg::NUM_GPIO-1:0];
        ao_periph_pkg::GPIO_INTR_EN_OFS: intr_en_q     <= bus.wdata[ao_periph_pkg::NUM_GPIO-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (ofs)
      ao_periph_pkg::GPIO_OUT_OFS: bus.rdata[ao_periph_pkg::NUM_GPIO-1:0] = cio_gpio_o;
      ao_periph_pkg::GPIO_EN_OFS:  bus.rdata[ao_periph_pkg::NUM_GPIO-1:0] = cio_gpio_en_o;
      ao_periph_pkg::GPIO_IN_OFS:  bus.rdata[ao_periph_pkg::NUM_GPIO-1:0] = gpio_in;
      default:                     bus.rdata[ao_periph_pkg::NUM_GPIO-1:0] = intr_en_q;
    endcase
  end

  // Level interrupt follows the synchronized pin
  assign intr_gpio_o = gpio_in & intr_en_q;

endmodule : gpio_ao

//--- verilog/reg_bus_if.sv
// Register bus between the adapter, the demux and the peripherals
// A transfer completes when valid and ready are both high

`timescale 1ns/1ps

interface reg_bus_if;

  // Request side
  logic                         valid;
  logic                         write;
  logic [ao_periph_pkg::AW-1:0] addr;
  logic [ao_periph_pkg::DW-1:0] wdata;

  // Response side, same cycle as the request
  logic [ao_periph_pkg::DW-1:0] rdata;
  logic                         ready;
  logic                         error;

  modport host (output valid, write, addr, wdata, input rdata, ready, error);

  modport device (input valid, write, addr, wdata, output rdata, ready, error);

endinterface : reg_bus_if

//--- verilog/soc_ctrl.sv
// SoC control registers
// Exit value and flag, boot select pin and instance ID readback

`timescale 1ns/1ps

module soc_ctrl (
  input  logic                         clk_i,
  input  logic                         reset_i,
  reg_bus_if.device                    bus,
  input  logic                         boot_select_i,
  output logic                         exit_valid_o,
  output logic [ao_periph_pkg::DW-1:0] exit_value_o
);

  logic [1:0] ofs;
  logic       wr;

  assign ofs = bus.addr[ao_periph_pkg::REG_OFS_MSB:ao_periph_pkg::REG_OFS_LSB];
  assign wr  = bus.valid & bus.write;

  assign bus.ready = 1'b1;
  assign bus.error = 1'b0;

  // BOOT_SEL and ID ignore writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (wr) begin
      if (ofs == ao_periph_pkg::SOC_EXIT_VALID_OFS) exit_valid_o <= bus.wdata[0];
      if (ofs == ao_periph_pkg::SOC_EXIT_VALUE_OFS) exit_value_o <= bus.wdata;
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (ofs)
      ao_periph_pkg::SOC_EXIT_VALID_OFS: bus.rdata[0] = exit_valid_o;
      ao_periph_pkg::SOC_EXIT_VALUE_OFS: bus.rdata = exit_value_o;
      ao_periph_pkg::SOC_BOOT_SEL_OFS:   bus.rdata[0] = boot_select_i;
      default:                           bus.rdata = ao_periph_pkg::AO_INSTANCE_ID;
    endcase
  end

endmodule : soc_ctrl
